// ==== hw/rv_pkg.sv ====
package rv_pkg;

    // ##################################################
    // widths and value types

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [31:0]     instr_t;

    // ##################################################
    // reset and identification values

    localparam xlen_t       RESET_PC      = 64'h0000_0000_8000_0000;
    localparam logic [31:0] MVENDORID_VAL = 32'h0000_0000;  // non-commercial implementation
    localparam xlen_t       MARCHID_VAL   = 64'h0000_0000_0000_002a;
    localparam xlen_t       MIMPID_VAL    = 64'h0000_0000_0001_0003;

    localparam xlen_t MTVEC_WMASK = ~64'h2;  // bit 1 of mtvec is reserved and reads as zero

    localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

    // ##################################################
    // machine CSR address map

    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET  = 12'hB02;
    localparam csr_addr_t CSR_MVENDORID = 12'hF11;
    localparam csr_addr_t CSR_MARCHID   = 12'hF12;
    localparam csr_addr_t CSR_MIMPID    = 12'hF13;
    localparam csr_addr_t CSR_MHARTID   = 12'hF14;

    // user-level read-only aliases of the machine counters
    localparam csr_addr_t CSR_CYCLE     = 12'hC00;
    localparam csr_addr_t CSR_TIME      = 12'hC01;  // no real-time clock, mirrors mcycle
    localparam csr_addr_t CSR_INSTRET   = 12'hC02;

    // ##################################################
    // encodings

    typedef enum logic [2:0] {
        CSRRW  = 3'b001,
        CSRRS  = 3'b010,
        CSRRC  = 3'b011,
        CSRRWI = 3'b101,
        CSRRSI = 3'b110,
        CSRRCI = 3'b111
    } csr_funct3_e;

    typedef enum logic [3:0] {
        EXC_ILLEGAL_INSTR = 4'd2
    } trap_cause_e;

endpackage

// ==== hw/csr_decode.sv ====
`timescale 1ns/1ps

module csr_decode import rv_pkg::*; (
    input  instr_t      instr,
    output logic        csr_op,
    output logic        not_csr,
    output csr_addr_t   csr_addr,
    output csr_funct3_e funct3,
    output reg_idx_t    rd,
    output reg_idx_t    rs1_uimm
);

    logic [6:0] opcode;
    logic [2:0] raw_funct3;
    logic       is_system;
    logic       is_csr_funct3;

    assign opcode     = instr[6:0];
    assign raw_funct3 = instr[14:12];
    assign is_system  = (opcode == OPC_SYSTEM);

    // ##################################################
    // funct3 check

    // 000 holds ECALL/EBREAK/MRET and 100 is unassigned, neither is a CSR access
    always_comb begin
        case (raw_funct3)
            3'b001,
            3'b010,
            3'b011,
            3'b101,
            3'b110,
            3'b111:  is_csr_funct3 = 1'b1;
            default: is_csr_funct3 = 1'b0;
        endcase
    end

    assign csr_op  = is_system && is_csr_funct3;
    assign not_csr = !csr_op;  // qualified by instr_valid in the top level

    // ##################################################
    // field extraction

    assign csr_addr = instr[31:20];
    assign funct3   = csr_funct3_e'(raw_funct3);
    assign rd       = instr[11:7];
    assign rs1_uimm = instr[19:15];  // rs1 index, or the 5-bit immediate for the I forms

endmodule

// ==== hw/int_regfile.sv ====
`timescale 1ns/1ps

module int_regfile import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    input  reg_idx_t rs_idx,
    output xlen_t    rs_data,

    input  logic     csr_we,
    input  reg_idx_t csr_idx,
    input  xlen_t    csr_data,

    input  logic     wb_we,
    input  reg_idx_t wb_idx,
    input  xlen_t    wb_data
);

    xlen_t regs [32];

    assign rs_data = regs[rs_idx];  // x0 is never written, so it stays zero

    // ##################################################
    // write ports

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_we && (wb_idx != '0)) begin
                regs[wb_idx] <= wb_data;
            end
            // the later assignment wins, so the CSR result beats the external writeback
            if (csr_we && (csr_idx != '0)) begin
                regs[csr_idx] <= csr_data;
            end
        end
    end

endmodule

// ==== hw/csrs.sv ====
`timescale 1ns/1ps

module csrs import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        inst_retired,

    input  logic        exec_csr_instr_valid,
    input  csr_addr_t   exec_csr_addr,
    input  csr_funct3_e exec_csr_funct3,
    input  reg_idx_t    exec_csr_rd,
    input  reg_idx_t    exec_csr_rs1_uimm,
    input  xlen_t       exec_csr_rs1_data,
    output logic        exec_csr_exception,
    output trap_cause_e exec_csr_trap_cause,
    output xlen_t       exec_csr_result,

    output xlen_t       mtvec
);

    // ##################################################
    // storage and access classification

    xlen_t csr_mtvec;
    xlen_t csr_mscratch;
    xlen_t csr_mcycle;
    xlen_t csr_minstret;

    xlen_t csr_rdata;
    xlen_t src_data;
    xlen_t write_data;
    logic  bad_addr;
    logic  is_rw;
    logic  is_imm;
    logic  is_write;
    logic  is_read;
    logic  is_readonly;
    logic  do_write;

    assign mtvec = csr_mtvec;

    assign is_rw       = (exec_csr_funct3 == CSRRW) || (exec_csr_funct3 == CSRRWI);
    assign is_imm      = (exec_csr_funct3 == CSRRWI) || (exec_csr_funct3 == CSRRSI) ||
                         (exec_csr_funct3 == CSRRCI);
    assign is_write    = is_rw || (exec_csr_rs1_uimm != '0);  // set/clear with zero source is a pure read
    assign is_read     = !is_rw || (exec_csr_rd != '0);  // csrrw into x0 does not read
    assign is_readonly = (exec_csr_addr[11:10] == 2'b11);

    assign exec_csr_exception  = bad_addr || (is_write && is_readonly);
    assign exec_csr_trap_cause = EXC_ILLEGAL_INSTR;
    assign exec_csr_result     = is_read ? csr_rdata : '0;

    assign do_write = exec_csr_instr_valid && is_write && !exec_csr_exception;

    // ##################################################
    // read mux

    always_comb begin
        bad_addr = 1'b0;
        case (exec_csr_addr)
            CSR_MTVEC:     csr_rdata = csr_mtvec;
            CSR_MSCRATCH:  csr_rdata = csr_mscratch;
            CSR_MCYCLE:    csr_rdata = csr_mcycle;
            CSR_MINSTRET:  csr_rdata = csr_minstret;
            CSR_MVENDORID: csr_rdata = {32'h0, MVENDORID_VAL};  // mvendorid is a 32-bit register
            CSR_MARCHID:   csr_rdata = MARCHID_VAL;
            CSR_MIMPID:    csr_rdata = MIMPID_VAL;
            CSR_MHARTID:   csr_rdata = '0;  // single hart
            CSR_CYCLE,
            CSR_TIME:      csr_rdata = csr_mcycle;
            CSR_INSTRET:   csr_rdata = csr_minstret;
            default: begin
                bad_addr  = 1'b1;
                csr_rdata = '0;
            end
        endcase
    end

    // ##################################################
    // read-modify-write

    assign src_data = is_imm ? {{(XLEN - 5){1'b0}}, exec_csr_rs1_uimm} : exec_csr_rs1_data;

    always_comb begin
        case (exec_csr_funct3)
            CSRRW,
            CSRRWI:  write_data = src_data;
            CSRRS,
            CSRRSI:  write_data = csr_rdata | src_data;
            CSRRC,
            CSRRCI:  write_data = csr_rdata & ~src_data;
            default: write_data = csr_rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            csr_mtvec    <= '0;
            csr_mscratch <= '0;
            csr_mcycle   <= '0;
            csr_minstret <= '0;
        end else begin
            csr_mcycle <= csr_mcycle + 1'b1;
            if (inst_retired) begin
                csr_minstret <= csr_minstret + 1'b1;
            end

            // an explicit write comes last and replaces this cycle's counter increment
            if (do_write) begin
                case (exec_csr_addr)
                    CSR_MTVEC:    csr_mtvec    <= write_data & MTVEC_WMASK;
                    CSR_MSCRATCH: csr_mscratch <= write_data;
                    CSR_MCYCLE:   csr_mcycle   <= write_data;
                    CSR_MINSTRET: csr_minstret <= write_data;
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== hw/trap_ctrl.sv ====
`timescale 1ns/1ps

module trap_ctrl import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  logic  instr_valid,
    input  logic  illegal,
    input  logic  wb_valid,
    input  xlen_t mtvec,

    output xlen_t pc,
    output logic  retired,
    output logic  exception,
    output logic  inst_retired
);

    logic  legal_valid;
    logic  illegal_valid;
    xlen_t trap_target;

    assign legal_valid   = instr_valid && !illegal;
    assign illegal_valid = instr_valid && illegal;
    assign trap_target   = {mtvec[XLEN-1:2], 2'b00};  // direct mode only, mode bits dropped

    // writebacks from the other units retire as well, minstret takes at most one per cycle
    assign inst_retired = legal_valid || wb_valid;

    // ##################################################
    // pc and retire/exception pulses

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= RESET_PC;
            retired   <= 1'b0;
            exception <= 1'b0;
        end else begin
            retired   <= legal_valid;
            exception <= illegal_valid;
            if (illegal_valid) begin
                pc <= trap_target;
            end else if (legal_valid) begin
                pc <= pc + 64'd4;
            end
        end
    end

endmodule

// ==== hw/csr_exec_top.sv ====
`timescale 1ns/1ps

module csr_exec_top import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        instr_valid,
    input  instr_t      instr,

    input  logic        wb_valid,
    input  reg_idx_t    wb_rd,
    input  xlen_t       wb_data,

    output logic        rd_we,
    output reg_idx_t    rd_idx,
    output xlen_t       rd_data,

    output xlen_t       pc,
    output logic        retired,
    output logic        exception,
    output trap_cause_e trap_cause
);

    logic        csr_op;
    logic        not_csr;
    csr_addr_t   csr_addr;
    csr_funct3_e funct3;
    reg_idx_t    rd;
    reg_idx_t    rs1_uimm;
    xlen_t       rs1_data;
    logic        csr_valid;
    logic        csr_exception;
    trap_cause_e csr_cause;
    xlen_t       csr_result;
    logic        csr_we;
    logic        illegal;
    logic        inst_retired;
    xlen_t       mtvec;

    assign csr_valid = instr_valid && csr_op;
    assign illegal   = (instr_valid && not_csr) || (csr_valid && csr_exception);
    assign csr_we    = csr_valid && !csr_exception && (rd != '0);

    // ##################################################
    // datapath

    csr_decode u_decode (
        .instr    (instr),
        .csr_op   (csr_op),
        .not_csr  (not_csr),
        .csr_addr (csr_addr),
        .funct3   (funct3),
        .rd       (rd),
        .rs1_uimm (rs1_uimm)
    );

    int_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs_idx   (rs1_uimm),
        .rs_data  (rs1_data),
        .csr_we   (csr_we),
        .csr_idx  (rd),
        .csr_data (csr_result),
        .wb_we    (wb_valid),
        .wb_idx   (wb_rd),
        .wb_data  (wb_data)
    );

    csrs u_csrs (
        .clk                  (clk),
        .rst                  (rst),
        .inst_retired         (inst_retired),
        .exec_csr_instr_valid (csr_valid),
        .exec_csr_addr        (csr_addr),
        .exec_csr_funct3      (funct3),
        .exec_csr_rd          (rd),
        .exec_csr_rs1_uimm    (rs1_uimm),
        .exec_csr_rs1_data    (rs1_data),
        .exec_csr_exception   (csr_exception),
        .exec_csr_trap_cause  (csr_cause),
        .exec_csr_result      (csr_result),
        .mtvec                (mtvec)
    );

    trap_ctrl u_trap (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .illegal      (illegal),
        .wb_valid     (wb_valid),
        .mtvec        (mtvec),
        .pc           (pc),
        .retired      (retired),
        .exception    (exception),
        .inst_retired (inst_retired)
    );

    // ##################################################
    // output registers

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_we <= 1'b0;
        end else begin
            rd_we <= csr_we;
        end
    end

    always_ff @(posedge clk) begin
        rd_idx     <= rd;
        rd_data    <= csr_result;
        trap_cause <= csr_cause;  // only meaningful while exception is high
    end

endmodule

// ==== tests/csr_exec_tb.sv ====
`timescale 1ns/1ps

module csr_exec_tb import rv_pkg::*; ();

    localparam int     WAIT_LIMIT = 20;
    localparam instr_t ECALL_WORD = 32'h0000_0073;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    instr_t      instr;
    logic        wb_valid;
    reg_idx_t    wb_rd;
    xlen_t       wb_data;
    logic        rd_we;
    reg_idx_t    rd_idx;
    xlen_t       rd_data;
    xlen_t       pc;
    logic        retired;
    logic        exception;
    trap_cause_e trap_cause;

    int    seed = 32'h7ae0a499;
    xlen_t exp_pc;
    xlen_t exp_mtvec;
    xlen_t exp_scratch;
    xlen_t reg_a;
    xlen_t reg_b;

    csr_exec_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .rd_we       (rd_we),
        .rd_idx      (rd_idx),
        .rd_data     (rd_data),
        .pc          (pc),
        .retired     (retired),
        .exception   (exception),
        .trap_cause  (trap_cause)
    );

    always #10 clk = ~clk;

    // ##################################################
    // compare tasks

    task automatic stop_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_cause(input string name, input trap_cause_e got,
                               input trap_cause_e exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    // ##################################################
    // drive helpers

    function automatic instr_t csr_word(csr_funct3_e f3, csr_addr_t addr, reg_idx_t rs1,
                                        reg_idx_t rd);
        return {addr, rs1, f3, rd, OPC_SYSTEM};
    endfunction

    task automatic load_reg(input reg_idx_t idx, input xlen_t value);
        wb_valid = 1'b1;
        wb_rd    = idx;
        wb_data  = value;
        @(posedge clk);
        #2;
        wb_valid = 1'b0;
    endtask

    // drive a one-cycle strobe and wait for the registered retire or exception pulse
    task automatic issue(input instr_t word, input logic expect_exc);
        int waited;
        instr_valid = 1'b1;
        instr       = word;
        @(posedge clk);
        #2;
        instr_valid = 1'b0;
        instr       = '0;
        wb_valid    = 1'b0;  // a writeback set up by the caller lasts one cycle too
        waited      = 0;
        while (!(retired || exception)) begin
            if (waited >= WAIT_LIMIT) begin
                $display("timeout: no retire or exception pulse after instruction 0x%h", word);
                stop_run();
            end
            @(posedge clk);
            #2;
            waited++;
        end
        check_bit("exception", exception, expect_exc);
        check_bit("retired", retired, !expect_exc);
        if (expect_exc) begin
            check_cause("trap_cause", trap_cause, EXC_ILLEGAL_INSTR);
            check_bit("rd_we", rd_we, 1'b0);
            exp_pc = exp_mtvec & ~64'h3;
        end else begin
            exp_pc = exp_pc + 64'd4;
        end
        check_xlen("pc", pc, exp_pc);
    endtask

    task automatic exec_csr(input csr_funct3_e f3, input csr_addr_t addr, input reg_idx_t rs1,
                            input reg_idx_t rd, input xlen_t exp_old);
        issue(csr_word(f3, addr, rs1, rd), 1'b0);
        check_bit("rd_we", rd_we, rd != '0);
        check_idx("rd_idx", rd_idx, rd);
        check_xlen("rd_data", rd_data, exp_old);
    endtask

    task automatic read_csr(input csr_addr_t addr, output xlen_t value);
        issue(csr_word(CSRRS, addr, 5'd0, 5'd5), 1'b0);
        check_bit("rd_we", rd_we, 1'b1);
        value = rd_data;
    endtask

    // ##################################################
    // directed tests

    task automatic id_and_reset_values();
        check_xlen("pc", pc, RESET_PC);
        check_bit("rd_we", rd_we, 1'b0);
        check_bit("retired", retired, 1'b0);
        check_bit("exception", exception, 1'b0);
        exec_csr(CSRRS, CSR_MVENDORID, 5'd0, 5'd5, xlen_t'(MVENDORID_VAL));
        exec_csr(CSRRS, CSR_MARCHID, 5'd0, 5'd5, MARCHID_VAL);
        exec_csr(CSRRS, CSR_MIMPID, 5'd0, 5'd5, MIMPID_VAL);
        exec_csr(CSRRS, CSR_MHARTID, 5'd0, 5'd5, 64'h0);
    endtask

    task automatic mscratch_rmw();
        reg_a = {$random(seed), $random(seed)};
        reg_b = {$random(seed), $random(seed)};
        load_reg(5'd6, reg_a);
        load_reg(5'd7, reg_b);
        exec_csr(CSRRW, CSR_MSCRATCH, 5'd6, 5'd5, exp_scratch);
        exp_scratch = reg_a;
        exec_csr(CSRRS, CSR_MSCRATCH, 5'd7, 5'd5, exp_scratch);
        exp_scratch = exp_scratch | reg_b;
        exec_csr(CSRRC, CSR_MSCRATCH, 5'd6, 5'd5, exp_scratch);
        exp_scratch = exp_scratch & ~reg_a;
        exec_csr(CSRRWI, CSR_MSCRATCH, 5'h15, 5'd5, exp_scratch);
        exp_scratch = 64'h15;
        exec_csr(CSRRSI, CSR_MSCRATCH, 5'h0a, 5'd5, exp_scratch);
        exp_scratch = exp_scratch | 64'h0a;
        exec_csr(CSRRCI, CSR_MSCRATCH, 5'h01, 5'd5, exp_scratch);
        exp_scratch = exp_scratch & ~64'h01;
        exec_csr(CSRRS, CSR_MSCRATCH, 5'd0, 5'd5, exp_scratch);
    endtask

    task automatic mtvec_masking();
        load_reg(5'd8, 64'h0000_0000_8000_0103);
        exec_csr(CSRRW, CSR_MTVEC, 5'd8, 5'd5, exp_mtvec);
        exp_mtvec = 64'h0000_0000_8000_0101;  // bit 1 never sticks
        exec_csr(CSRRSI, CSR_MTVEC, 5'h02, 5'd5, exp_mtvec);
        exec_csr(CSRRS, CSR_MTVEC, 5'd0, 5'd5, exp_mtvec);
    endtask

    task automatic counter_reads();
        xlen_t first;
        xlen_t second;
        xlen_t stamp;
        read_csr(CSR_INSTRET, first);
        for (int i = 0; i < 5; i++) begin
            issue(csr_word(CSRRS, CSR_MSCRATCH, 5'd0, 5'd0), 1'b0);
        end
        read_csr(CSR_INSTRET, second);
        check_xlen("instret delta", second - first, 64'd6);  // the first read retires too
        read_csr(CSR_CYCLE, first);
        read_csr(CSR_CYCLE, second);
        check_xlen("cycle delta", second - first, 64'd1);
        read_csr(CSR_TIME, stamp);
        check_xlen("time", stamp, second + 64'd1);
        read_csr(CSR_MCYCLE, first);
        check_xlen("mcycle", first, stamp + 64'd1);
    endtask

    task automatic illegal_accesses();
        xlen_t value;
        issue(csr_word(CSRRW, 12'h7c0, 5'd6, 5'd5), 1'b1);
        issue(csr_word(CSRRW, CSR_MHARTID, 5'd6, 5'd5), 1'b1);
        issue(ECALL_WORD, 1'b1);
        issue({CSR_MSCRATCH, 5'd0, 3'b100, 5'd5, OPC_SYSTEM}, 1'b1);
        read_csr(CSR_MHARTID, value);
        check_xlen("rd_data", value, 64'h0);
    endtask

    task automatic writeback_collision();
        xlen_t first;
        xlen_t second;
        xlen_t old_scratch;
        read_csr(CSR_INSTRET, first);
        old_scratch = exp_scratch;
        wb_valid = 1'b1;
        wb_rd    = 5'd9;
        wb_data  = ~reg_a;
        exec_csr(CSRRW, CSR_MSCRATCH, 5'd6, 5'd9, old_scratch);
        exp_scratch = reg_a;
        read_csr(CSR_INSTRET, second);
        check_xlen("instret delta", second - first, 64'd2);
        // x9 must hold the CSR result and is copied back into mscratch to see it
        exec_csr(CSRRW, CSR_MSCRATCH, 5'd9, 5'd5, exp_scratch);
        exp_scratch = old_scratch;
        exec_csr(CSRRS, CSR_MSCRATCH, 5'd0, 5'd5, exp_scratch);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        wb_valid    = 1'b0;
        wb_rd       = '0;
        wb_data     = '0;
        exp_pc      = RESET_PC;
        exp_mtvec   = '0;
        exp_scratch = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        id_and_reset_values();
        mscratch_rmw();
        mtvec_masking();
        counter_reads();
        illegal_accesses();
        writeback_collision();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== csr_exec_top.f ====
hw/rv_pkg.sv
hw/csr_decode.sv
hw/int_regfile.sv
hw/csrs.sv
hw/trap_ctrl.sv
hw/csr_exec_top.sv
tests/csr_exec_tb.sv

// ==== Bender.yml ====
package:
  name: csr_exec

sources:
  - files:
      - hw/rv_pkg.sv
      - hw/csr_decode.sv
      - hw/int_regfile.sv
      - hw/csrs.sv
      - hw/trap_ctrl.sv
      - hw/csr_exec_top.sv
  - target: test
    files:
      - tests/csr_exec_tb.sv
